// File: bench/clk_gen.sv
// testbench clock and reset source, 4 ns period, reset held for 5 cycles
module clk_gen
(
   output logic clk,
   output logic arst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;                          // 4 ns period
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;                                 // release on an edge like the stimulus
   end

endmodule

// File: bench/exe_ref.svh
// reference model: forwarding, alu result, next pc, reload request and memory-stage record
`ifndef EXE_REF_SVH
`define EXE_REF_SVH

// value a source sees once the forwarding paths are applied
function automatic logic [xlen-1:0] fwd_ref(input logic rd, input logic [gpr_asz-1:0] addr,
                                            input logic [xlen-1:0] rf,
                                            input fwd_gpr_t fm, input fwd_gpr_t fw);
   logic [xlen-1:0] v;
   v = rf;
   if (rd && addr != '0 && fw.valid && fw.rd_wr && fw.rd_addr == addr)
      v = fw.rd_data;                                 // older result first
   if (rd && addr != '0 && fm.valid && fm.rd_wr && fm.rd_addr == addr)
      v = fm.rd_data;                                 // younger one overrides it
   return v;
endfunction

function automatic logic [xlen-1:0] alu_ref(input d2e_t d, input logic [xlen-1:0] a,
                                            input logic [xlen-1:0] b);
   logic [xlen-1:0]   x;
   logic [xlen-1:0]   y;
   logic [xlen-1:0]   r;
   logic [2*xlen-1:0] wide;
   x    = (d.sel_x == sx_pc) ? d.pc : ((d.sel_x == sx_zero) ? '0 : a);
   y    = (d.sel_y == sy_imm) ? d.imm : b;
   wide = {{xlen{x[xlen-1]}}, x} >> y[4:0];         // sign-filled copy gives sra
   case (d.op.alu)
      op_add:  r = x + y;
      op_sub:  r = x + ~y + 32'd1;
      op_sll:  r = x << y[4:0];
      op_slt:  r = {31'd0, $signed(x) < $signed(y)};
      op_sltu: r = {31'd0, x < y};
      op_xor:  r = x ^ y;
      op_srl:  r = x >> y[4:0];
      op_sra:  r = wide[xlen-1:0];
      op_or:   r = x | y;
      op_and:  r = x & y;
      default: r = '0;
   endcase
   return r;
endfunction

// where the program really goes after this branch or jump
function automatic logic [xlen-1:0] br_target_ref(input d2e_t d, input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
   logic            taken;
   logic [xlen-1:0] t;
   case (d.funct3)
      3'd0:    taken = (a == b);
      3'd1:    taken = (a != b);
      3'd4:    taken = $signed(a) < $signed(b);
      3'd5:    taken = !($signed(a) < $signed(b));
      3'd6:    taken = a < b;
      3'd7:    taken = !(a < b);
      default: taken = 1'b0;
   endcase
   t = d.pc + 32'd4;
   if (d.op.br.op == b_jal || (d.op.br.op == b_cond && taken))
      t = d.pc + d.imm;
   else if (d.op.br.op == b_jalr)
      t = (a + d.imm) & ~32'd1;
   return t;
endfunction

function automatic logic reload_ref(input d2e_t d, input logic [xlen-1:0] a,
                                    input logic [xlen-1:0] b);
   logic [xlen-1:0] t;
   t = br_target_ref(d, a, b);
   return (d.ig_type == br_instr) && !t[1] && (t != d.predicted_addr);
endfunction

function automatic e2m_t e2m_ref(input d2e_t d, input logic [xlen-1:0] a,
                                 input logic [xlen-1:0] b);
   e2m_t            r;
   logic [xlen-1:0] t;
   logic [xlen-1:0] ea;
   logic [xlen-1:0] bytes;
   r         = '0;
   r.pc      = d.pc;
   r.ig_type = d.ig_type;
   r.rd_addr = d.rd_addr;
   t         = br_target_ref(d, a, b);
   ea        = a + d.imm;
   bytes     = 32'd1 << d.funct3[1:0];
   if (d.ig_type == alu_instr)
   begin
      r.rd_wr   = d.rd_wr;
      r.rd_data = alu_ref(d, a, b);
   end
   else if (d.ig_type == br_instr)
   begin
      r.br_pc  = t;
      r.mis    = t[1];                                // halfword target, no compressed
      r.mispre = !t[1] && (t != d.predicted_addr);
      if (!t[1] && !r.mispre && d.op.br.op != b_cond)
      begin
         r.rd_wr   = d.rd_wr;                         // link address on the right path only
         r.rd_data = d.pc + 32'd4;
      end
   end
   else if (d.ig_type == ld_instr || d.ig_type == st_instr)
   begin
      r.is_ld    = (d.ig_type == ld_instr);
      r.is_st    = (d.ig_type == st_instr);
      r.rd_wr    = r.is_ld && d.rd_wr;
      r.ls_addr  = ea;
      r.st_data  = r.is_st ? b : '0;
      r.size     = d.funct3[1:0];
      r.zero_ext = r.is_ld && d.funct3[2];
      r.mis      = (ea & (bytes - 32'd1)) != '0;
      r.inv_flag = r.is_st && (ea >= l1_ic_lo) && (ea <= l1_ic_hi);
   end
   r.rd_wr = r.rd_wr && (d.rd_addr != '0);
   return r;
endfunction

`endif

// File: bench/execute_tb.sv
// execute stage testbench: random instructions, reference compare, timeout and result report
module execute_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import exe_pkg::*;

   localparam int num_txn        = 1000;
   localparam int timeout_cycles = 8000;              // 1000 instructions at up to 6 cycles + margin

   logic                          clk;
   logic                          arst_n;
   logic                          cpu_halt;
   logic                          pipe_flush;
   logic                          d2e_valid;
   d2e_t                          d2e_data;
   logic                          d2e_rdy;
   logic                          e2m_valid;
   e2m_t                          e2m_data;
   logic                          e2m_rdy;
   logic [max_gpr-1:0][xlen-1:0]  gpr;
   fwd_gpr_t                      fwd_mem;
   fwd_gpr_t                      fwd_wb;
   logic                          rld_pc_flag;
   logic [xlen-1:0]               rld_pc_addr;
   e2m_t                          exp_q[$];           // records accepted, not yet out
   int                            cycles = 0;

   `include "exe_ref.svh"

   clk_gen clk_src (.clk(clk), .arst_n(arst_n));

   execute execute_i
   (
      .clk(clk), .arst_n(arst_n), .cpu_halt(cpu_halt), .pipe_flush(pipe_flush),
      .d2e_valid(d2e_valid), .d2e_data(d2e_data), .d2e_rdy(d2e_rdy),
      .e2m_valid(e2m_valid), .e2m_data(e2m_data), .e2m_rdy(e2m_rdy),
      .gpr(gpr), .fwd_mem(fwd_mem), .fwd_wb(fwd_wb),
      .rld_pc_flag(rld_pc_flag), .rld_pc_addr(rld_pc_addr)
   );

   // --------------------------------------------------
   // failure reporting and compare tasks
   // --------------------------------------------------
   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_e2m(input string name, input e2m_t exp, input e2m_t act);
      if (exp !== act)
         report_failure($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_reload(input string name, input logic exp_flag,
                               input logic [xlen-1:0] exp_addr, input logic act_flag,
                               input logic [xlen-1:0] act_addr);
      if (act_flag !== exp_flag || (exp_flag && act_addr !== exp_addr))
         report_failure($sformatf("[FAIL] %s expected flag %b addr %h actual flag %b addr %h",
                                  name, exp_flag, exp_addr, act_flag, act_addr));
   endtask

   // --------------------------------------------------
   // random instruction and forward generation
   // --------------------------------------------------
   function automatic logic [gpr_asz-1:0] pick_reg();
      logic [gpr_asz-1:0] r;
      r = gpr_asz'($urandom);
      if ($urandom_range(0, 1) == 1)
         r = gpr_asz'($urandom_range(0, 3));          // small set so sources and forwards collide
      return r;
   endfunction

   function automatic fwd_gpr_t make_fwd();
      fwd_gpr_t f;
      f.valid   = 1'($urandom);
      f.rd_wr   = 1'($urandom);
      f.rd_addr = pick_reg();
      f.rd_data = $urandom;
      return f;
   endfunction

   task automatic make_instr(output d2e_t d);
      logic [31:0] r;
      r          = $urandom;
      d          = '0;
      d.ig_type  = ig_type_e'(3'($urandom_range(0, 4)));
      d.pc       = $urandom & 32'hffff_fffc;
      d.imm      = {{20{r[11]}}, r[11:0]};            // i-type range, sign extended
      d.funct3   = 3'($urandom);
      d.rd_addr  = pick_reg();
      d.rs1_addr = pick_reg();
      d.rs2_addr = pick_reg();
      d.rd_wr    = 1'($urandom);
      d.rs1_rd   = 1'($urandom);
      d.rs2_rd   = 1'($urandom);
      d.sel_x    = alu_sel_x_e'(2'($urandom_range(0, 2)));
      d.sel_y    = alu_sel_y_e'(1'($urandom));
      d.op.alu   = alu_op_e'(4'($urandom_range(0, 9)));
      case (d.ig_type)
         br_instr:
         begin
            d.imm[0]   = 1'b0;                        // bit 1 left random for misaligned targets
            d.op.br.op = br_op_e'(2'($urandom_range(0, 2)));
            d.funct3   = 3'($urandom_range(0, 5));
            if (d.funct3 >= 3'd2)
               d.funct3 = d.funct3 + 3'd2;            // skip 010 and 011
         end
         ld_instr:
         begin
            d.funct3 = 3'($urandom_range(0, 4));      // lb lh lw lbu lhu
            if (d.funct3 >= 3'd3)
               d.funct3 = d.funct3 + 3'd1;
         end
         st_instr: d.funct3 = 3'($urandom_range(0, 2));
         default: ;
      endcase
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   initial
   begin
      d2e_t                         nxt;
      logic [max_gpr-1:0][xlen-1:0] g;
      fwd_gpr_t                     fm;
      fwd_gpr_t                     fw;
      logic [xlen-1:0]              a;
      logic [xlen-1:0]              b;
      void'($urandom(32'h9b8e));
      d2e_valid = 1'b0;
      d2e_data  = '0;
      gpr       = '0;
      fwd_mem   = '0;
      fwd_wb    = '0;
      @(posedge arst_n);
      for (int n = 0; n < num_txn; n++)
      begin
         @(posedge clk);
         make_instr(nxt);
         g = '0;                                      // x0 reads zero from the register file
         for (int i = 1; i < max_gpr; i++)
         begin
            g[i] = $urandom;
            if ($urandom_range(0, 1) == 1)
               g[i] = g[i] & 32'h0000_ffff;           // low bases put stores near the I$ range
         end
         fm = make_fwd();
         fw = make_fwd();
         a  = fwd_ref(nxt.rs1_rd, nxt.rs1_addr, g[nxt.rs1_addr], fm, fw);
         b  = fwd_ref(nxt.rs2_rd, nxt.rs2_addr, g[nxt.rs2_addr], fm, fw);
         case ($urandom_range(0, 3))
            0:       nxt.predicted_addr = $urandom;
            1:       nxt.predicted_addr = nxt.pc + 32'd4;
            default: nxt.predicted_addr = br_target_ref(nxt, a, b);   // fetch guessed right
         endcase
         d2e_data  <= nxt;
         d2e_valid <= 1'b1;
         gpr       <= g;
         fwd_mem   <= fm;
         fwd_wb    <= fw;
         @(negedge clk);
         while (!d2e_rdy)
            @(negedge clk);                           // held until the transfer edge
         if ($urandom_range(0, 7) == 0)
         begin
            @(posedge clk);
            d2e_valid <= 1'b0;                        // bubble
         end
      end
      @(posedge clk);
      d2e_valid <= 1'b0;
      while (exp_q.size() != 0)
         @(negedge clk);
      $display("Finished with no errors");
      $finish;
   end

   // memory side back-pressure, halt and flush
   initial
   begin
      e2m_rdy    = 1'b0;
      cpu_halt   = 1'b0;
      pipe_flush = 1'b0;
      forever
      begin
         @(posedge clk);
         e2m_rdy    <= ($urandom_range(0, 3) != 0);   // stall about one cycle in four
         cpu_halt   <= ($urandom_range(0, 15) == 0);
         pipe_flush <= ($urandom_range(0, 31) == 0);
      end
   end

   // --------------------------------------------------
   // compare, mid-cycle where everything is settled
   // --------------------------------------------------
   always @(negedge clk)
   begin
      e2m_t            exp;
      logic [xlen-1:0] a;
      logic [xlen-1:0] b;
      if (!arst_n)
      begin
         if (e2m_valid || d2e_rdy || rld_pc_flag)
            report_failure("outputs were not idle during reset");
      end
      else
      begin
         if (cpu_halt && d2e_rdy)
            report_failure("d2e_rdy was high while cpu_halt was set");
         if (e2m_valid && e2m_rdy)
         begin
            if (exp_q.size() == 0)
               report_failure("a record came out with none expected");
            exp = exp_q.pop_front();
            check_e2m($sformatf("e2m record pc %h", exp.pc), exp, e2m_data);
         end
         else if (e2m_valid && pipe_flush && exp_q.size() != 0)
            exp = exp_q.pop_front();                  // held record dies in the flush
         if (d2e_valid && d2e_rdy)
         begin
            a = fwd_ref(d2e_data.rs1_rd, d2e_data.rs1_addr, gpr[d2e_data.rs1_addr],
                        fwd_mem, fwd_wb);
            b = fwd_ref(d2e_data.rs2_rd, d2e_data.rs2_addr, gpr[d2e_data.rs2_addr],
                        fwd_mem, fwd_wb);
            check_reload($sformatf("reload pc %h", d2e_data.pc), reload_ref(d2e_data, a, b),
                         br_target_ref(d2e_data, a, b), rld_pc_flag, rld_pc_addr);
            if (!pipe_flush)
               exp_q.push_back(e2m_ref(d2e_data, a, b));   // a flush also kills the write
         end
         else
            check_reload("reload without transfer", 1'b0, '0, rld_pc_flag, rld_pc_addr);
      end
   end

   // run limit
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles)
         report_failure("the run did not finish within the cycle limit");
   end

endmodule

// File: filelist.f
+incdir+bench
verilog/exe_pkg.sv
verilog/operand_fwd.sv
verilog/alu_fu.sv
verilog/br_fu.sv
verilog/ls_fu.sv
verilog/exe_pipe.sv
verilog/execute.sv
bench/clk_gen.sv
bench/execute_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing -f filelist.f --top-module execute_tb -o execute_tb_sim \
   && ./obj_dir/execute_tb_sim \
   || exit 1

// File: verilog/alu_fu.sv
// ALU functional unit: operand select and the RV32I integer operations
module alu_fu
(
   input  logic [exe_pkg::xlen-1:0] rs1,
   input  logic [exe_pkg::xlen-1:0] rs2,
   input  logic [exe_pkg::xlen-1:0] pc,
   input  logic [exe_pkg::xlen-1:0] imm,
   input  exe_pkg::alu_sel_x_e      sel_x,
   input  exe_pkg::alu_sel_y_e      sel_y,
   input  exe_pkg::alu_op_e         op,
   output logic [exe_pkg::xlen-1:0] rd_data
);
   import exe_pkg::*;

   logic [xlen-1:0] x;                                // first operand
   logic [xlen-1:0] y;                                // second operand
   logic [4:0]      shamt;

   // auipc uses pc, lui uses zero + imm
   always_comb
   begin
      case (sel_x)
         sx_pc:   x = pc;
         sx_zero: x = '0;
         default: x = rs1;
      endcase
   end

   assign y     = (sel_y == sy_imm) ? imm : rs2;
   assign shamt = y[4:0];                             // rv32 shifts only look at 5 bits

   always_comb
   begin
      case (op)
         op_add:  rd_data = x + y;
         op_sub:  rd_data = x - y;
         op_sll:  rd_data = x << shamt;
         op_slt:  rd_data = xlen'($signed(x) < $signed(y));
         op_sltu: rd_data = xlen'(x < y);
         op_xor:  rd_data = x ^ y;
         op_srl:  rd_data = x >> shamt;
         op_sra:  rd_data = $unsigned($signed(x) >>> shamt);   // keep the sign bit
         op_or:   rd_data = x | y;
         op_and:  rd_data = x & y;
         default: rd_data = '0;                       // codes 10..15 unused
      endcase
   end

endmodule

// File: verilog/br_fu.sv
// branch functional unit: condition, next pc, link address and target alignment
module br_fu
(
   input  logic [exe_pkg::xlen-1:0] rs1,
   input  logic [exe_pkg::xlen-1:0] rs2,
   input  logic [exe_pkg::xlen-1:0] pc,
   input  logic [exe_pkg::xlen-1:0] imm,
   input  logic [2:0]               funct3,
   input  exe_pkg::br_op_e          op,
   output logic [exe_pkg::xlen-1:0] br_pc,           // real next pc
   output logic [exe_pkg::xlen-1:0] no_br_pc,        // fall through, also link address
   output logic                     mis               // target not on a word boundary
);
   import exe_pkg::*;

   logic            take;                             // conditional branch is taken
   logic [xlen-1:0] jalr_sum;

   assign no_br_pc = pc + 32'd4;
   assign jalr_sum = rs1 + imm;

   // ------------------------------------------------
   // branch condition by funct3
   // ------------------------------------------------
   always_comb
   begin
      case (funct3)
         3'b000:  take = (rs1 == rs2);                       // beq
         3'b001:  take = (rs1 != rs2);                       // bne
         3'b100:  take = ($signed(rs1) < $signed(rs2));      // blt
         3'b101:  take = ($signed(rs1) >= $signed(rs2));     // bge
         3'b110:  take = (rs1 < rs2);                        // bltu
         3'b111:  take = (rs1 >= rs2);                       // bgeu
         default: take = 1'b0;                               // 010, 011 are no branch
      endcase
   end

   // ------------------------------------------------
   // next pc
   // ------------------------------------------------
   always_comb
   begin
      case (op)
         b_cond:  br_pc = take ? (pc + imm) : no_br_pc;
         b_jal:   br_pc = pc + imm;
         b_jalr:  br_pc = {jalr_sum[xlen-1:1], 1'b0};        // spec drops bit 0
         default: br_pc = no_br_pc;
      endcase
   end

   // no compressed support, so a target on a halfword is misaligned
   assign mis = br_pc[1];

endmodule

// File: verilog/exe_pipe.sv
// one entry pipeline register with full flag between execute and memory
module exe_pipe
(
   input  logic          clk,
   input  logic          arst_n,
   input  logic          flush,                       // drop whatever is held
   input  logic          write,                       // load data_in
   input  logic          read,                        // next stage takes data_out
   input  exe_pkg::e2m_t data_in,
   output logic          full,
   output exe_pkg::e2m_t data_out
);

   // flush beats a write in the same cycle, the younger instruction dies too
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         full <= 1'b0;
      else if (flush)
         full <= 1'b0;
      else if (write)
         full <= 1'b1;                                // write with read keeps it full
      else if (read)
         full <= 1'b0;
   end

   // payload only, qualified by full
   always_ff @(posedge clk)
   begin
      if (write)
         data_out <= data_in;
   end

endmodule

// File: verilog/exe_pkg.sv
// execute stage package: widths, cache range, enums, op union and pipeline records
package exe_pkg;

   // --------------------------------------------------
   // widths and address ranges
   // --------------------------------------------------
   localparam int xlen    = 32;                       // data and pc width
   localparam int gpr_asz = 5;                        // register address width
   localparam int max_gpr = 32;                       // general registers

   // stores landing in here also hit the L1 I$ and must invalidate it
   localparam logic [31:0] l1_ic_lo = 32'h0000_0000;
   localparam logic [31:0] l1_ic_hi = 32'h0000_7fff;  // inclusive

   // --------------------------------------------------
   // instruction classes and operations
   // --------------------------------------------------
   typedef enum logic [2:0]
   {
      alu_instr,
      br_instr,
      ld_instr,
      st_instr,
      ill_instr                                       // passed on, trapped later
   } ig_type_e;

   typedef enum logic [3:0]
   {
      op_add, op_sub, op_sll, op_slt, op_sltu,
      op_xor, op_srl, op_sra, op_or, op_and
   } alu_op_e;

   typedef enum logic [1:0]
   {
      b_cond,                                         // beq .. bgeu, picked by funct3
      b_jal,
      b_jalr
   } br_op_e;

   typedef enum logic [1:0] {sx_rs1, sx_pc, sx_zero} alu_sel_x_e;   // first alu operand
   typedef enum logic       {sy_rs2, sy_imm} alu_sel_y_e;           // second alu operand

   // branch view of the op word, upper bits unused
   typedef struct packed
   {
      logic [1:0] pad;
      br_op_e     op;
   } br_op_t;

   // op word means an alu op or a branch op depending on ig_type
   typedef union packed
   {
      alu_op_e alu;
      br_op_t  br;
   } exe_op_u;

   // --------------------------------------------------
   // pipeline records
   // --------------------------------------------------
   typedef struct packed
   {
      logic [xlen-1:0]    pc;
      logic [xlen-1:0]    predicted_addr;             // where fetch went after this one
      logic [xlen-1:0]    imm;
      ig_type_e           ig_type;
      exe_op_u            op;
      logic [2:0]         funct3;
      logic [gpr_asz-1:0] rd_addr;
      logic [gpr_asz-1:0] rs1_addr;
      logic [gpr_asz-1:0] rs2_addr;
      logic               rd_wr;
      logic               rs1_rd;
      logic               rs2_rd;
      alu_sel_x_e         sel_x;
      alu_sel_y_e         sel_y;
   } d2e_t;

   typedef struct packed
   {
      logic               valid;
      logic               rd_wr;
      logic [gpr_asz-1:0] rd_addr;
      logic [xlen-1:0]    rd_data;
   } fwd_gpr_t;

   typedef struct packed
   {
      logic [xlen-1:0]    pc;
      ig_type_e           ig_type;
      logic               rd_wr;
      logic [gpr_asz-1:0] rd_addr;
      logic [xlen-1:0]    rd_data;
      logic               is_ld;
      logic               is_st;
      logic [xlen-1:0]    ls_addr;
      logic [xlen-1:0]    st_data;
      logic [1:0]         size;                       // funct3[1:0]: byte, half, word
      logic               zero_ext;
      logic               inv_flag;                   // store hits the I$ range
      logic               mis;                        // misaligned target or access
      logic               mispre;                     // fetch took the wrong path
      logic [xlen-1:0]    br_pc;
   } e2m_t;

endpackage

// File: verilog/execute.sv
// execute stage top: handshake, forwarding, functional units, result record, pc reload
module execute
(
   input  logic                                           clk,
   input  logic                                           arst_n,
   input  logic                                           cpu_halt,    // stop taking instrs
   input  logic                                           pipe_flush,  // kill the held record
   input  logic                                           d2e_valid,
   input  exe_pkg::d2e_t                                  d2e_data,
   output logic                                           d2e_rdy,
   output logic                                           e2m_valid,
   output exe_pkg::e2m_t                                  e2m_data,
   input  logic                                           e2m_rdy,
   input  logic [exe_pkg::max_gpr-1:0][exe_pkg::xlen-1:0] gpr,
   input  exe_pkg::fwd_gpr_t                              fwd_mem,
   input  exe_pkg::fwd_gpr_t                              fwd_wb,
   output logic                                           rld_pc_flag, // fetch must reload
   output logic [exe_pkg::xlen-1:0]                       rld_pc_addr
);
   import exe_pkg::*;

   logic            run_q;                            // first clock after reset seen
   logic            xfer_in;
   logic            xfer_out;
   logic            pipe_full;
   logic            rld_req;                          // instruction mispredicts
   logic [xlen-1:0] rs1_d;                            // forwarded sources
   logic [xlen-1:0] rs2_d;
   logic [xlen-1:0] alu_rd_data;
   logic [xlen-1:0] br_pc;
   logic [xlen-1:0] no_br_pc;
   logic            br_mis;
   logic [xlen-1:0] ls_addr;
   logic [xlen-1:0] st_data;
   logic [1:0]      ls_size;
   logic            ls_zero_ext;
   logic            ls_mis;
   e2m_t            exe_dout;

   // --------------------------------------------------
   // handshake
   // --------------------------------------------------
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         run_q <= 1'b0;
      else
         run_q <= 1'b1;
   end

   assign d2e_rdy     = run_q & ~cpu_halt & (~pipe_full | xfer_out);
   assign xfer_in     = d2e_valid & d2e_rdy;
   assign xfer_out    = e2m_valid & e2m_rdy;
   assign e2m_valid   = pipe_full;
   assign rld_pc_flag = xfer_in & rld_req;            // only for an accepted instruction

   // --------------------------------------------------
   // operands and functional units
   // --------------------------------------------------
   operand_fwd rs1_fwd
   (
      .rd(d2e_data.rs1_rd), .addr(d2e_data.rs1_addr), .rf_data(gpr[d2e_data.rs1_addr]),
      .fwd_mem(fwd_mem), .fwd_wb(fwd_wb), .opnd(rs1_d)
   );

   operand_fwd rs2_fwd
   (
      .rd(d2e_data.rs2_rd), .addr(d2e_data.rs2_addr), .rf_data(gpr[d2e_data.rs2_addr]),
      .fwd_mem(fwd_mem), .fwd_wb(fwd_wb), .opnd(rs2_d)
   );

   alu_fu afu
   (
      .rs1(rs1_d), .rs2(rs2_d), .pc(d2e_data.pc), .imm(d2e_data.imm),
      .sel_x(d2e_data.sel_x), .sel_y(d2e_data.sel_y), .op(d2e_data.op.alu),
      .rd_data(alu_rd_data)
   );

   br_fu bfu
   (
      .rs1(rs1_d), .rs2(rs2_d), .pc(d2e_data.pc), .imm(d2e_data.imm),
      .funct3(d2e_data.funct3), .op(d2e_data.op.br.op),
      .br_pc(br_pc), .no_br_pc(no_br_pc), .mis(br_mis)
   );

   ls_fu lsfu
   (
      .rs1(rs1_d), .rs2(rs2_d), .imm(d2e_data.imm), .funct3(d2e_data.funct3),
      .ls_addr(ls_addr), .st_data(st_data), .size(ls_size),
      .zero_ext(ls_zero_ext), .mis(ls_mis)
   );

   // --------------------------------------------------
   // result record and reload
   // --------------------------------------------------
   always_comb
   begin
      exe_dout         = '0;
      exe_dout.pc      = d2e_data.pc;
      exe_dout.ig_type = d2e_data.ig_type;
      exe_dout.rd_addr = d2e_data.rd_addr;
      rld_req          = 1'b0;
      rld_pc_addr      = '0;

      case (d2e_data.ig_type)
         alu_instr:
         begin
            exe_dout.rd_wr   = d2e_data.rd_wr;
            exe_dout.rd_data = alu_rd_data;
         end

         br_instr:
         begin
            exe_dout.br_pc = br_pc;
            if (br_mis)
               exe_dout.mis = 1'b1;                   // trap later, fetch keeps going
            else if (d2e_data.predicted_addr != br_pc)
            begin
               exe_dout.mispre = 1'b1;
               rld_req         = 1'b1;
               rld_pc_addr     = br_pc;
            end
            else if (d2e_data.op.br.op != b_cond)
            begin
               exe_dout.rd_wr   = d2e_data.rd_wr;     // link only on the right path
               exe_dout.rd_data = no_br_pc;
            end
         end

         ld_instr:
         begin
            exe_dout.rd_wr    = d2e_data.rd_wr;       // data arrives in memory stage
            exe_dout.is_ld    = 1'b1;
            exe_dout.ls_addr  = ls_addr;
            exe_dout.size     = ls_size;
            exe_dout.zero_ext = ls_zero_ext;
            exe_dout.mis      = ls_mis;
         end

         st_instr:
         begin
            exe_dout.is_st    = 1'b1;
            exe_dout.ls_addr  = ls_addr;
            exe_dout.st_data  = st_data;
            exe_dout.size     = ls_size;
            exe_dout.inv_flag = (ls_addr >= l1_ic_lo) && (ls_addr <= l1_ic_hi);
            exe_dout.mis      = ls_mis;
         end

         default: ;                                   // illegal: no effect, trapped downstream
      endcase

      exe_dout.rd_wr = exe_dout.rd_wr & (|d2e_data.rd_addr);   // x0 is never written
   end

   exe_pipe exe_reg
   (
      .clk(clk), .arst_n(arst_n), .flush(pipe_flush),
      .write(xfer_in), .read(xfer_out), .data_in(exe_dout),
      .full(pipe_full), .data_out(e2m_data)
   );

endmodule

// File: verilog/ls_fu.sv
// load/store unit: effective address, access size, extension, alignment, store data
module ls_fu
(
   input  logic [exe_pkg::xlen-1:0] rs1,             // base
   input  logic [exe_pkg::xlen-1:0] rs2,             // store value
   input  logic [exe_pkg::xlen-1:0] imm,             // offset
   input  logic [2:0]               funct3,
   output logic [exe_pkg::xlen-1:0] ls_addr,
   output logic [exe_pkg::xlen-1:0] st_data,
   output logic [1:0]               size,            // 0 byte, 1 half, 2 word
   output logic                     zero_ext,        // lbu / lhu
   output logic                     mis
);

   assign ls_addr  = rs1 + imm;
   assign st_data  = rs2;                             // memory stage lines up the lanes
   assign size     = funct3[1:0];
   assign zero_ext = funct3[2];

   // alignment by access width
   always_comb
   begin
      case (size)
         2'b01:   mis = ls_addr[0];                   // halfword on odd byte
         2'b10:   mis = |ls_addr[1:0];                // word off a 4 byte boundary
         default: mis = 1'b0;                         // bytes never misalign
      endcase
   end

endmodule

// File: verilog/operand_fwd.sv
// source operand mux picking memory forward, writeback forward or register file
module operand_fwd
(
   input  logic                        rd,            // instruction really reads this source
   input  logic [exe_pkg::gpr_asz-1:0] addr,          // source register
   input  logic [exe_pkg::xlen-1:0]    rf_data,       // gpr[addr]
   input  exe_pkg::fwd_gpr_t           fwd_mem,       // result now in memory stage
   input  exe_pkg::fwd_gpr_t           fwd_wb,        // result now in writeback stage
   output logic [exe_pkg::xlen-1:0]    opnd
);

   logic mem_hit;
   logic wb_hit;
   logic addr_nz;                                     // x0 always reads as zero

   assign addr_nz = |addr;

   // a forward counts only if it is live, writes a register and hits ours
   assign mem_hit = rd & addr_nz & fwd_mem.valid & fwd_mem.rd_wr &
                    (fwd_mem.rd_addr == addr);
   assign wb_hit  = rd & addr_nz & fwd_wb.valid & fwd_wb.rd_wr &
                    (fwd_wb.rd_addr == addr);

   // newest value wins, memory stage is younger than writeback
   always_comb
   begin
      if (mem_hit)
         opnd = fwd_mem.rd_data;
      else if (wb_hit)
         opnd = fwd_wb.rd_data;
      else
         opnd = rf_data;                              // nothing in flight for this register
   end

endmodule
